// ==== verilog.f ====
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/core_pipe_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/riscv_core.sv
dv/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module core_tb -o core_sim

./obj_dir/core_sim > sim.log
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
exit 0

// ==== dv/core_stim.hex ====
// Program length N, then N instruction words
// Store count M, then M lines of expected store address and data
0000002E
10000093 // addi x1,x0,0x100
FF800113 // addi x2,x0,-8
40115193 // srai x3,x2,1
0030A023 // sw x3,0(x1)
00012233 // slt x4,x2,x0
001132B3 // sltu x5,x2,x1
0040A223 // sw x4,4(x1)
0050A423 // sw x5,8(x1)
12345337 // lui x6,0x12345
67830313 // addi x6,x6,0x678
00001397 // auipc x7,1
0060A623 // sw x6,12(x1)
0070A823 // sw x7,16(x1)
40730433 // sub x8,x6,x7
002444B3 // xor x9,x8,x2
0090AA23 // sw x9,20(x1)
00C0A503 // lw x10,12(x1)
00150593 // addi x11,x10,1
00B0AC23 // sw x11,24(x1)
00500013 // addi x0,x0,5
0000AE23 // sw x0,28(x1)
00520463 // beq x4,x5,+8 not taken
00521463 // bne x4,x5,+8 taken
0020A023 // sw x2,0(x1) skipped
00414463 // blt x2,x4,+8 taken
0020A023 // skipped
00415463 // bge x2,x4,+8 not taken
00416463 // bltu x2,x4,+8 not taken
00417463 // bgeu x2,x4,+8 taken
0020A023 // skipped
0080066F // jal x12,+8
0020A023 // skipped
02C0A023 // sw x12,32(x1)
09400693 // addi x13,x0,148
00068767 // jalr x14,0(x13)
0020A023 // skipped
0020A023 // skipped
02E0A223 // sw x14,36(x1)
003217B3 // sll x15,x4,x3
00415833 // srl x16,x2,x4
02F0A423 // sw x15,40(x1)
0300A623 // sw x16,44(x1)
0F087893 // andi x17,x16,0xf0
00F8E913 // ori x18,x17,0xf
0320A823 // sw x18,48(x1)
0000006F // jal x0,0
0000000D
00000100 FFFFFFFC
00000104 00000001
00000108 00000000
0000010C 12345678
00000110 00001028
00000114 EDCBB9A8
00000118 12345679
0000011C 00000000
00000120 0000007C
00000124 0000008C
00000128 10000000
0000012C 7FFFFFFC
00000130 000000FF

// ==== dv/core_tb.sv ====
// Core testbench

`include "core_settings.svh"

module core_tb;

  logic        Clock;
  logic        reset;
  logic [31:0] PcQ100H;
  logic [31:0] PreInstructionQ101H;
  logic [31:0] DMemAddressQ103H;
  logic [31:0] DMemWrDataQ103H;
  logic [3:0]  DMemByteEnQ103H;
  logic        DMemWrEnQ103H;
  logic        DMemRdEnQ103H;
  logic [31:0] DMemRdRspQ104H;

  logic [31:0] stim [0:255]; // Raw stim words
  logic [31:0] iMem [0:255]; // Word-indexed instruction memory
  logic [31:0] dMem [0:1023]; // Word-indexed data memory
  logic [31:0] expAddr [$];   // Expected store sequence
  logic [31:0] expData [$];
  logic [31:0] fetchPc;       // PC taken at the last rising edge
  logic [31:0] readAddr;      // Load address taken at the last rising edge
  int          progLen;
  int          storesExpected;
  int          storeCount;
  int          dataErrors;
  int          otherErrors;
  int          cycleCount;
  int          cycleLimit;

  riscv_core UUT (.*);

  always #2 Clock = ~Clock; // Period 4

  //////////////////////////////////////////////////
  // Stim loading and reset
  //////////////////////////////////////////////////
  initial begin
    Clock               = 1'b0;
    reset               = 1'b1;
    PreInstructionQ101H = `CORE_NOP;
    DMemRdRspQ104H      = '0;
    fetchPc             = '0;
    readAddr            = '0;
    storeCount          = 0;
    dataErrors          = 0;
    otherErrors         = 0;
    cycleCount          = 0;
    $readmemh("dv/core_stim.hex", stim);
    progLen = stim[0];
    for (int i = 0; i < 256; i++) begin
      iMem[i] = `CORE_NOP; // Past the program
    end
    for (int i = 0; i < progLen; i++) begin
      iMem[i] = stim[1 + i];
    end
    storesExpected = stim[progLen + 1];
    for (int i = 0; i < storesExpected; i++) begin
      expAddr.push_back(stim[progLen + 2 + 2 * i]);
      expData.push_back(stim[progLen + 3 + 2 * i]);
    end
    for (int i = 0; i < 1024; i++) begin
      dMem[i] = '0;
    end
    cycleLimit = 16 + 4 * progLen + 64; // Reset, program, drain
    repeat (16) @(negedge Clock);
    reset = 1'b0;
  end

  // Compare one store with the next expected pair
  task automatic checkStore(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] mask);
    if (storeCount >= expAddr.size()) begin
      otherErrors++;
      $display("Unexpected extra store of %h to %h at time %0t", data, addr, $time);
    end else begin
      assert (addr == expAddr[storeCount] && data == expData[storeCount] && mask == 4'hf)
      else begin
        dataErrors++;
        $display("FAILED at time %0t: store %0d wrote %h to %h mask %b, expected %h to %h",
                 $time, storeCount, data, addr, mask, expData[storeCount],
                 expAddr[storeCount]);
      end
      storeCount++;
    end
  endtask

  // Summary and verdict
  task automatic finishRun();
    $display("Stores seen %0d of %0d, value errors %0d, other errors %0d",
             storeCount, storesExpected, dataErrors, otherErrors);
    if (dataErrors == 0 && otherErrors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////
  // Memory models
  //////////////////////////////////////////////////
  always @(posedge Clock) begin
    cycleCount++;
    fetchPc = PcQ100H; // Word comes back next cycle
    if (reset) begin
      // Both enables stay low until reset is released
      assert (DMemWrEnQ103H !== 1'b1 && DMemRdEnQ103H !== 1'b1)
      else begin
        otherErrors++;
        $display("Data memory access issued while reset is high at time %0t", $time);
      end
    end
    if (DMemRdEnQ103H === 1'b1) readAddr = DMemAddressQ103H;
    if (DMemWrEnQ103H === 1'b1) begin
      if (!reset) begin
        checkStore(DMemAddressQ103H, DMemWrDataQ103H, DMemByteEnQ103H);
      end
      dMem[DMemAddressQ103H[11:2]] = DMemWrDataQ103H;
    end
    // Run ends on the last store or the cycle limit
    if (storesExpected > 0 && storeCount >= storesExpected) begin
      finishRun();
    end else if (cycleCount >= cycleLimit) begin
      otherErrors++;
      $display("Timeout after %0d cycles, only %0d of %0d stores seen",
               cycleCount, storeCount, storesExpected);
      finishRun();
    end
  end

  // Instruction and load data back to the core
  always @(negedge Clock) begin
    PreInstructionQ101H <= iMem[fetchPc[9:2]];
    DMemRdRspQ104H      <= dMem[readAddr[11:2]];
  end

endmodule

// ==== hdl/riscv_core.sv ====
// Five-stage RV32I core

module riscv_core (
  input  logic                   Clock,
  input  logic                   reset,
  output core_pipe_pkg::pcWord   PcQ100H,             // To instruction memory
  input  rv_isa_pkg::instrWord   PreInstructionQ101H, // From instruction memory
  output core_pipe_pkg::dataWord DMemAddressQ103H,
  output core_pipe_pkg::dataWord DMemWrDataQ103H,
  output core_pipe_pkg::byteMask DMemByteEnQ103H,
  output logic                   DMemWrEnQ103H,
  output logic                   DMemRdEnQ103H,
  input  core_pipe_pkg::dataWord DMemRdRspQ104H
);

  // Fetch and decode
  logic                   stall, redirect;
  core_pipe_pkg::pcWord   redirectTarget, PcQ101H, PcPlus4Q101H, PcQ102H, PcPlus4Q102H;
  core_pipe_pkg::regAddr  Src1Q101H, Src2Q101H;
  core_pipe_pkg::dataWord RdData1Q101H, RdData2Q101H;
  // Decode to execute
  rv_isa_pkg::aluOp       aluOpQ102H;
  rv_isa_pkg::branchType  branchOpQ102H;
  logic                   selPcQ102H, selImmQ102H, luiQ102H, isBranchQ102H, isJumpQ102H;
  logic                   linkQ102H, regWrEnQ102H, memRdQ102H, memWrQ102H;
  core_pipe_pkg::regAddr  DstQ102H, Src1Q102H, Src2Q102H;
  core_pipe_pkg::dataWord ImmQ102H, RdData1Q102H, RdData2Q102H;
  // Execute to memory
  core_pipe_pkg::dataWord AluOutQ103H, StoreDataQ103H;
  core_pipe_pkg::regAddr  DstQ103H;
  logic                   RegWrEnQ103H, MemRdQ103H, MemWrQ103H, LinkQ103H;
  core_pipe_pkg::pcWord   PcPlus4Q103H;
  // Write-back
  logic                   WrEnQ104H;
  core_pipe_pkg::regAddr  WrDstQ104H;
  core_pipe_pkg::dataWord WrDataQ104H;

  fetch_stage fetch (.*);

  decode_stage decode (.*);

  register_file regFile (.*);

  execute_stage execute (.*);

  memory_stage memory (.*);

endmodule

// ==== hdl/memory_stage.sv ====
// Memory access and write-back

module memory_stage (
  input  logic                    Clock,
  input  logic                    reset,
  input  core_pipe_pkg::dataWord  AluOutQ103H,
  input  core_pipe_pkg::dataWord  StoreDataQ103H,
  input  core_pipe_pkg::regAddr   DstQ103H,
  input  logic                    RegWrEnQ103H,
  input  logic                    MemRdQ103H,
  input  logic                    MemWrQ103H,
  input  logic                    LinkQ103H,
  input  core_pipe_pkg::pcWord    PcPlus4Q103H,
  input  core_pipe_pkg::dataWord  DMemRdRspQ104H,   // One cycle after the read
  output core_pipe_pkg::dataWord  DMemAddressQ103H,
  output core_pipe_pkg::dataWord  DMemWrDataQ103H,
  output core_pipe_pkg::byteMask  DMemByteEnQ103H,
  output logic                    DMemWrEnQ103H,
  output logic                    DMemRdEnQ103H,
  output logic                    WrEnQ104H,
  output core_pipe_pkg::regAddr   WrDstQ104H,
  output core_pipe_pkg::dataWord  WrDataQ104H
);

  core_pipe_pkg::dataWord aluOutQ104H;
  core_pipe_pkg::pcWord   pcPlus4Q104H;
  logic                   linkQ104H;
  logic                   loadQ104H;

  // Word access only
  assign DMemAddressQ103H = AluOutQ103H;
  assign DMemWrDataQ103H  = StoreDataQ103H;
  assign DMemByteEnQ103H  = MemWrQ103H ? 4'b1111 : 4'b0000;
  assign DMemWrEnQ103H    = MemWrQ103H;
  assign DMemRdEnQ103H    = MemRdQ103H;

  //////////////////////////////////////////////////
  // Q103 to Q104
  //////////////////////////////////////////////////
  always_ff @(posedge Clock) begin
    if (reset) WrEnQ104H <= 1'b0;
    else       WrEnQ104H <= RegWrEnQ103H;
  end

  always_ff @(posedge Clock) begin
    aluOutQ104H  <= AluOutQ103H;
    pcPlus4Q104H <= PcPlus4Q103H;
    linkQ104H    <= LinkQ103H;
    loadQ104H    <= MemRdQ103H;
    WrDstQ104H   <= DstQ103H;
  end

  // Link first, then load data, else ALU
  assign WrDataQ104H = linkQ104H ? pcPlus4Q104H   :
                       loadQ104H ? DMemRdRspQ104H :
                                   aluOutQ104H;

endmodule

// ==== hdl/execute_stage.sv ====
// Execute

module execute_stage (
  input  logic                   Clock,
  input  logic                   reset,
  input  rv_isa_pkg::aluOp       aluOpQ102H,
  input  rv_isa_pkg::branchType  branchOpQ102H,
  input  logic                   selPcQ102H,
  input  logic                   selImmQ102H,
  input  logic                   luiQ102H,
  input  logic                   isBranchQ102H,
  input  logic                   isJumpQ102H,
  input  logic                   linkQ102H,
  input  logic                   regWrEnQ102H,
  input  logic                   memRdQ102H,
  input  logic                   memWrQ102H,
  input  core_pipe_pkg::regAddr  DstQ102H,
  input  core_pipe_pkg::regAddr  Src1Q102H,
  input  core_pipe_pkg::regAddr  Src2Q102H,
  input  core_pipe_pkg::dataWord ImmQ102H,
  input  core_pipe_pkg::pcWord   PcQ102H,
  input  core_pipe_pkg::pcWord   PcPlus4Q102H,
  input  core_pipe_pkg::dataWord RdData1Q102H,
  input  core_pipe_pkg::dataWord RdData2Q102H,
  input  logic                   WrEnQ104H,      // Write-back from memory stage
  input  core_pipe_pkg::regAddr  WrDstQ104H,
  input  core_pipe_pkg::dataWord WrDataQ104H,
  output logic                   redirect,
  output core_pipe_pkg::pcWord   redirectTarget,
  output core_pipe_pkg::dataWord AluOutQ103H,
  output core_pipe_pkg::dataWord StoreDataQ103H,
  output core_pipe_pkg::regAddr  DstQ103H,
  output logic                   RegWrEnQ103H,
  output logic                   MemRdQ103H,
  output logic                   MemWrQ103H,
  output logic                   LinkQ103H,
  output core_pipe_pkg::pcWord   PcPlus4Q103H
);

  core_pipe_pkg::dataWord src1DataQ102H;
  core_pipe_pkg::dataWord src2DataQ102H;
  core_pipe_pkg::dataWord aluIn1Q102H;
  core_pipe_pkg::dataWord aluIn2Q102H;
  core_pipe_pkg::dataWord aluOutQ102H;
  logic                   condMetQ102H;

  // Newest producer wins
  function automatic core_pipe_pkg::dataWord forward(input core_pipe_pkg::regAddr src,
                                                     input core_pipe_pkg::dataWord regData);
    if (RegWrEnQ103H && (DstQ103H == src)) begin
      return AluOutQ103H;
    end else if (WrEnQ104H && (WrDstQ104H == src)) begin
      return WrDataQ104H;
    end
    return regData;
  endfunction

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////
  always_comb begin
    src1DataQ102H = forward(Src1Q102H, RdData1Q102H);
    src2DataQ102H = forward(Src2Q102H, RdData2Q102H);
    aluIn1Q102H   = selPcQ102H  ? PcQ102H  : src1DataQ102H;
    aluIn2Q102H   = selImmQ102H ? ImmQ102H : src2DataQ102H;
    case (aluOpQ102H)
      rv_isa_pkg::SUB:  aluOutQ102H = aluIn1Q102H - aluIn2Q102H;
      rv_isa_pkg::SLL:  aluOutQ102H = aluIn1Q102H << aluIn2Q102H[4:0];
      rv_isa_pkg::SLT:  aluOutQ102H = {31'b0, $signed(aluIn1Q102H) < $signed(aluIn2Q102H)};
      rv_isa_pkg::SLTU: aluOutQ102H = {31'b0, aluIn1Q102H < aluIn2Q102H};
      rv_isa_pkg::XOR:  aluOutQ102H = aluIn1Q102H ^ aluIn2Q102H;
      rv_isa_pkg::SRL:  aluOutQ102H = aluIn1Q102H >> aluIn2Q102H[4:0];
      rv_isa_pkg::SRA:  aluOutQ102H = $signed(aluIn1Q102H) >>> aluIn2Q102H[4:0];
      rv_isa_pkg::OR:   aluOutQ102H = aluIn1Q102H | aluIn2Q102H;
      rv_isa_pkg::AND:  aluOutQ102H = aluIn1Q102H & aluIn2Q102H;
      default:          aluOutQ102H = aluIn1Q102H + aluIn2Q102H; // Also addresses, targets
    endcase
    if (luiQ102H) aluOutQ102H = aluIn2Q102H; // Upper immediate passes through
  end

  // Branch compare on forwarded registers
  always_comb begin
    case (branchOpQ102H)
      rv_isa_pkg::BEQ:  condMetQ102H = src1DataQ102H == src2DataQ102H;
      rv_isa_pkg::BNE:  condMetQ102H = src1DataQ102H != src2DataQ102H;
      rv_isa_pkg::BLT:  condMetQ102H = $signed(src1DataQ102H) < $signed(src2DataQ102H);
      rv_isa_pkg::BGE:  condMetQ102H = $signed(src1DataQ102H) >= $signed(src2DataQ102H);
      rv_isa_pkg::BLTU: condMetQ102H = src1DataQ102H < src2DataQ102H;
      rv_isa_pkg::BGEU: condMetQ102H = src1DataQ102H >= src2DataQ102H;
      default:          condMetQ102H = 1'b0;
    endcase
  end

  assign redirect       = (isBranchQ102H && condMetQ102H) || isJumpQ102H;
  assign redirectTarget = {aluOutQ102H[31:1], 1'b0}; // JALR drops bit 0

  //////////////////////////////////////////////////
  // Q102 to Q103
  //////////////////////////////////////////////////
  always_ff @(posedge Clock) begin
    if (reset) begin
      RegWrEnQ103H <= 1'b0;
      MemRdQ103H   <= 1'b0;
      MemWrQ103H   <= 1'b0;
    end else begin
      RegWrEnQ103H <= regWrEnQ102H;
      MemRdQ103H   <= memRdQ102H;
      MemWrQ103H   <= memWrQ102H;
    end
  end

  always_ff @(posedge Clock) begin
    AluOutQ103H    <= aluOutQ102H;
    StoreDataQ103H <= src2DataQ102H;
    DstQ103H       <= DstQ102H;
    LinkQ103H      <= linkQ102H;
    PcPlus4Q103H   <= PcPlus4Q102H;
  end

endmodule

// ==== hdl/register_file.sv ====
// Integer register file

module register_file (
  input  logic                   Clock,
  input  logic                   reset,
  input  core_pipe_pkg::regAddr  Src1Q101H,
  input  core_pipe_pkg::regAddr  Src2Q101H,
  input  logic                   WrEnQ104H,
  input  core_pipe_pkg::regAddr  WrDstQ104H,
  input  core_pipe_pkg::dataWord WrDataQ104H,
  output core_pipe_pkg::dataWord RdData1Q101H,
  output core_pipe_pkg::dataWord RdData2Q101H
);

  core_pipe_pkg::dataWord regs [1:31]; // x0 has no storage
  logic                   wrGoQ104H;

  assign wrGoQ104H = WrEnQ104H && !reset && (WrDstQ104H != '0);

  always_ff @(posedge Clock) begin
    if (wrGoQ104H) begin
      regs[WrDstQ104H] <= WrDataQ104H;
    end
  end

  // One read port
  function automatic core_pipe_pkg::dataWord readPort(input core_pipe_pkg::regAddr src);
    if (src == '0) begin
      return '0;
    end else if (wrGoQ104H && (src == WrDstQ104H)) begin
      return WrDataQ104H; // Write-through bypass
    end
    return regs[src];
  endfunction

  always_comb begin
    RdData1Q101H = readPort(Src1Q101H);
    RdData2Q101H = readPort(Src2Q101H);
  end

endmodule

// ==== hdl/decode_stage.sv ====
// Instruction decode

`include "core_settings.svh"

module decode_stage (
  input  logic                   Clock,
  input  logic                   reset,
  input  rv_isa_pkg::instrWord   PreInstructionQ101H, // From instruction memory
  input  core_pipe_pkg::pcWord   PcQ101H,
  input  core_pipe_pkg::pcWord   PcPlus4Q101H,
  input  logic                   redirect,            // Flush from execute
  input  core_pipe_pkg::dataWord RdData1Q101H,
  input  core_pipe_pkg::dataWord RdData2Q101H,
  output logic                   stall,
  output core_pipe_pkg::regAddr  Src1Q101H,
  output core_pipe_pkg::regAddr  Src2Q101H,
  output rv_isa_pkg::aluOp       aluOpQ102H,
  output rv_isa_pkg::branchType  branchOpQ102H,
  output logic                   selPcQ102H,          // ALU input 1 is PC
  output logic                   selImmQ102H,         // ALU input 2 is immediate
  output logic                   luiQ102H,
  output logic                   isBranchQ102H,
  output logic                   isJumpQ102H,
  output logic                   linkQ102H,           // Write back PC plus 4
  output logic                   regWrEnQ102H,
  output logic                   memRdQ102H,
  output logic                   memWrQ102H,
  output core_pipe_pkg::regAddr  DstQ102H,
  output core_pipe_pkg::regAddr  Src1Q102H,
  output core_pipe_pkg::regAddr  Src2Q102H,
  output core_pipe_pkg::dataWord ImmQ102H,
  output core_pipe_pkg::pcWord   PcQ102H,
  output core_pipe_pkg::pcWord   PcPlus4Q102H,
  output core_pipe_pkg::dataWord RdData1Q102H,
  output core_pipe_pkg::dataWord RdData2Q102H
);

  logic                   replayQ101H;    // Second pass of a stalled instruction
  logic                   redirectQ103H;  // Second flush slot
  logic                   firstSlotQ101H; // Slot after reset repeats the reset PC
  rv_isa_pkg::instrWord   heldInstrQ101H;
  rv_isa_pkg::instrWord   rawInstrQ101H;
  rv_isa_pkg::instrWord   instrQ101H;
  rv_isa_pkg::opcode      opcodeQ101H;
  rv_isa_pkg::aluOp       aluOpQ101H;
  rv_isa_pkg::immType     immTypeQ101H;
  core_pipe_pkg::dataWord immQ101H;

  //////////////////////////////////////////////////
  // Hazards
  //////////////////////////////////////////////////
  assign rawInstrQ101H = replayQ101H ? heldInstrQ101H : PreInstructionQ101H;

  // Load in Q102 feeding this instruction
  assign stall = memRdQ102H && regWrEnQ102H &&
                 ((rawInstrQ101H[19:15] == DstQ102H) || (rawInstrQ101H[24:20] == DstQ102H));

  assign instrQ101H = (stall || redirect || redirectQ103H || firstSlotQ101H) ? `CORE_NOP
                                                                             : rawInstrQ101H;

  assign Src1Q101H   = instrQ101H[19:15];
  assign Src2Q101H   = instrQ101H[24:20];
  assign opcodeQ101H = rv_isa_pkg::opcode'(instrQ101H[6:0]);

  //////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////
  always_comb begin
    case (instrQ101H[14:12])
      3'b000:  aluOpQ101H = (opcodeQ101H == rv_isa_pkg::R_OP && instrQ101H[30]) ?
                            rv_isa_pkg::SUB : rv_isa_pkg::ADD;
      3'b001:  aluOpQ101H = rv_isa_pkg::SLL;
      3'b010:  aluOpQ101H = rv_isa_pkg::SLT;
      3'b011:  aluOpQ101H = rv_isa_pkg::SLTU;
      3'b100:  aluOpQ101H = rv_isa_pkg::XOR;
      3'b101:  aluOpQ101H = instrQ101H[30] ? rv_isa_pkg::SRA : rv_isa_pkg::SRL;
      3'b110:  aluOpQ101H = rv_isa_pkg::OR;
      default: aluOpQ101H = rv_isa_pkg::AND;
    endcase
    // Address and target math always adds
    if (opcodeQ101H != rv_isa_pkg::R_OP && opcodeQ101H != rv_isa_pkg::I_OP) begin
      aluOpQ101H = rv_isa_pkg::ADD;
    end
  end

  // Immediate builder
  always_comb begin
    case (opcodeQ101H)
      rv_isa_pkg::STORE:            immTypeQ101H = rv_isa_pkg::IMM_S;
      rv_isa_pkg::BRANCH:           immTypeQ101H = rv_isa_pkg::IMM_B;
      rv_isa_pkg::LUI, rv_isa_pkg::AUIPC: immTypeQ101H = rv_isa_pkg::IMM_U;
      rv_isa_pkg::JAL:              immTypeQ101H = rv_isa_pkg::IMM_J;
      default:                      immTypeQ101H = rv_isa_pkg::IMM_I; // JALR, LOAD, I_OP
    endcase
    case (immTypeQ101H)
      rv_isa_pkg::IMM_S: immQ101H = {{20{instrQ101H[31]}}, instrQ101H[31:25], instrQ101H[11:7]};
      rv_isa_pkg::IMM_B: immQ101H = {{20{instrQ101H[31]}}, instrQ101H[7], instrQ101H[30:25],
                                     instrQ101H[11:8], 1'b0};
      rv_isa_pkg::IMM_U: immQ101H = {instrQ101H[31:12], 12'b0};
      rv_isa_pkg::IMM_J: immQ101H = {{12{instrQ101H[31]}}, instrQ101H[19:12], instrQ101H[20],
                                     instrQ101H[30:21], 1'b0};
      default:           immQ101H = {{20{instrQ101H[31]}}, instrQ101H[31:20]};
    endcase
  end

  //////////////////////////////////////////////////
  // Q101 to Q102
  //////////////////////////////////////////////////
  always_ff @(posedge Clock) begin
    if (reset) begin
      regWrEnQ102H  <= 1'b0;
      memRdQ102H    <= 1'b0;
      memWrQ102H    <= 1'b0;
      isBranchQ102H <= 1'b0;
      isJumpQ102H   <= 1'b0;
      redirectQ103H <= 1'b0;
      replayQ101H   <= 1'b0;
    end else begin
      // x0 destination never writes, so forwarding ignores it too
      regWrEnQ102H  <= (instrQ101H[11:7] != '0) &&
                       (opcodeQ101H inside {rv_isa_pkg::LUI, rv_isa_pkg::AUIPC, rv_isa_pkg::JAL,
                                            rv_isa_pkg::JALR, rv_isa_pkg::LOAD,
                                            rv_isa_pkg::I_OP, rv_isa_pkg::R_OP});
      memRdQ102H    <= opcodeQ101H == rv_isa_pkg::LOAD;
      memWrQ102H    <= opcodeQ101H == rv_isa_pkg::STORE;
      isBranchQ102H <= opcodeQ101H == rv_isa_pkg::BRANCH;
      isJumpQ102H   <= opcodeQ101H inside {rv_isa_pkg::JAL, rv_isa_pkg::JALR};
      redirectQ103H <= redirect;
      replayQ101H   <= stall;
    end
  end

  always_ff @(posedge Clock) begin
    firstSlotQ101H <= reset;
    heldInstrQ101H <= PreInstructionQ101H; // Copy for replay
    aluOpQ102H     <= aluOpQ101H;
    branchOpQ102H  <= rv_isa_pkg::branchType'(instrQ101H[14:12]);
    selPcQ102H     <= opcodeQ101H inside {rv_isa_pkg::JAL, rv_isa_pkg::BRANCH, rv_isa_pkg::AUIPC};
    selImmQ102H    <= opcodeQ101H != rv_isa_pkg::R_OP;
    luiQ102H       <= opcodeQ101H == rv_isa_pkg::LUI;
    linkQ102H      <= opcodeQ101H inside {rv_isa_pkg::JAL, rv_isa_pkg::JALR};
    DstQ102H       <= instrQ101H[11:7];
    Src1Q102H      <= Src1Q101H;
    Src2Q102H      <= Src2Q101H;
    ImmQ102H       <= immQ101H;
    PcQ102H        <= PcQ101H;
    PcPlus4Q102H   <= PcPlus4Q101H;
    RdData1Q102H   <= RdData1Q101H;
    RdData2Q102H   <= RdData2Q101H;
  end

endmodule

// ==== hdl/fetch_stage.sv ====
// Instruction fetch

`include "core_settings.svh"

module fetch_stage (
  input  logic                 Clock,
  input  logic                 reset,
  input  logic                 stall,          // Load-use bubble from decode
  input  logic                 redirect,       // Taken branch or jump in Q102
  input  core_pipe_pkg::pcWord redirectTarget,
  output core_pipe_pkg::pcWord PcQ100H,        // To instruction memory
  output core_pipe_pkg::pcWord PcQ101H,
  output core_pipe_pkg::pcWord PcPlus4Q101H
);

  core_pipe_pkg::pcWord pcPlus4Q100H;

  assign pcPlus4Q100H = PcQ100H + 32'd4;

  //////////////////////////////////////////////////
  // Program counter
  //////////////////////////////////////////////////
  always_ff @(posedge Clock) begin
    if (reset) begin
      PcQ100H <= `CORE_RESET_PC;
    end else if (redirect) begin
      PcQ100H <= redirectTarget; // Target fetched next cycle
    end else if (!stall) begin
      PcQ100H <= pcPlus4Q100H;
    end
  end

  //////////////////////////////////////////////////
  // Q100 to Q101
  //////////////////////////////////////////////////
  always_ff @(posedge Clock) begin
    if (!stall) begin // Held while decode replays
      PcQ101H      <= PcQ100H;
      PcPlus4Q101H <= pcPlus4Q100H;
    end
  end

endmodule

// ==== hdl/core_pipe_pkg.sv ====
// Pipeline datapath types

`include "core_settings.svh"

package core_pipe_pkg;

  // Register, ALU and memory data
  typedef logic [`CORE_XLEN-1:0] dataWord;

  // Program counters
  typedef logic [`CORE_XLEN-1:0] pcWord;

  // Register index
  typedef logic [`CORE_REG_ADDR_W-1:0] regAddr;

  // Data memory lane enables
  typedef logic [3:0] byteMask;

endpackage

// ==== hdl/rv_isa_pkg.sv ====
// RV32I encodings

package rv_isa_pkg;

  typedef logic [31:0] instrWord; // Fixed by the ISA

  // Major opcodes of the kept subset
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    I_OP   = 7'b0010011,
    R_OP   = 7'b0110011
  } opcode;

  // ALU functions
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND
  } aluOp;

  // Branch kinds with funct3 values
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branchType;

  // Immediate layouts
  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } immType;

endpackage

// ==== hdl/core_settings.svh ====
// Core width and reset settings

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath
`define CORE_XLEN        32 // Data and address width
`define CORE_REG_ADDR_W  5  // 32 architectural registers

// Start of execution
`define CORE_RESET_PC    32'h0000_0000

// ADDI x0,x0,0 for squashed slots
`define CORE_NOP         32'h0000_0013

`endif
